/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_lsu_mem
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/byte_lane_ram.sv */
`timescale 1ns/1ps

module byte_lane_ram #(
    parameter int MEM_AW = 6
) (
    input  logic                       clk,
    input  logic [MEM_AW-1:0]          addr_i,
    input  logic                       we_i,
    input  logic [mem_pkg::LANE_W-1:0] wdata_i,
    output logic [mem_pkg::LANE_W-1:0] rdata_o
);

    // one byte of every doubleword
    logic [mem_pkg::LANE_W-1:0] mem [2**MEM_AW];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // read before write, old contents on a write cycle
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
    end

endmodule

/* hw/lsu_load_extract.sv */
`timescale 1ns/1ps

module lsu_load_extract (
    input  logic [mem_pkg::XLEN-1:0]  lane_rdata_i,
    input  logic                      ld_valid_i,
    input  lsu_pkg::ls_op_e           ld_op_i,
    input  logic [mem_pkg::OFS_W-1:0] ld_ofs_i,
    output logic [mem_pkg::XLEN-1:0]  rdata_o,
    output logic                      rvalid_o
);

    lsu_pkg::ls_size_e         size;
    logic [mem_pkg::OFS_W-1:0] start;
    logic [mem_pkg::XLEN-1:0]  field;
    logic [mem_pkg::XLEN-1:0]  ext;
    logic                      uns;

    assign size = lsu_pkg::op_size(ld_op_i);

    // zero extension only for the unsigned loads
    assign uns = (ld_op_i == lsu_pkg::LBU) || (ld_op_i == lsu_pkg::LHU) ||
                 (ld_op_i == lsu_pkg::LWU);

    // same alignment as the store side
    always_comb begin
        case (size)
            lsu_pkg::SZ_B: start = ld_ofs_i;
            lsu_pkg::SZ_H: start = {ld_ofs_i[2:1], 1'b0};
            lsu_pkg::SZ_W: start = {ld_ofs_i[2], 2'b00};
            default:       start = '0;
        endcase
    end

    // field moved down to bit 0
    assign field = lane_rdata_i >> {start, 3'b000};

    always_comb begin
        case (size)
            lsu_pkg::SZ_B: begin
                ext = {{(mem_pkg::XLEN-8){~uns & field[7]}}, field[7:0]};
            end
            lsu_pkg::SZ_H: begin
                ext = {{(mem_pkg::XLEN-16){~uns & field[15]}}, field[15:0]};
            end
            lsu_pkg::SZ_W: begin
                ext = {{(mem_pkg::XLEN-32){~uns & field[31]}}, field[31:0]};
            end
            default: begin
                ext = field;
            end
        endcase
    end

    // data held at zero outside the valid cycle
    assign rvalid_o = ld_valid_i;
    assign rdata_o  = ld_valid_i ? ext : '0;

endmodule

/* hw/lsu_mem_top.sv */
`timescale 1ns/1ps

module lsu_mem_top #(
    parameter int MEM_AW = 6
) (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             req_i,
    input  lsu_pkg::ls_op_e                  op_i,
    input  logic [MEM_AW+mem_pkg::OFS_W-1:0] addr_i,
    input  logic [mem_pkg::XLEN-1:0]         wdata_i,
    output logic [mem_pkg::XLEN-1:0]         rdata_o,
    output logic                             rvalid_o
);

    logic [MEM_AW-1:0]         lane_addr;
    logic [mem_pkg::LANES-1:0] lane_we;
    logic [mem_pkg::XLEN-1:0]  lane_wdata;
    logic [mem_pkg::XLEN-1:0]  lane_rdata;
    logic                      ld_valid;
    lsu_pkg::ls_op_e           ld_op;
    logic [mem_pkg::OFS_W-1:0] ld_ofs;

    lsu_store_align #(
        .MEM_AW (MEM_AW)
    ) u_align (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .lane_addr_o  (lane_addr),
        .lane_we_o    (lane_we),
        .lane_wdata_o (lane_wdata),
        .ld_valid_o   (ld_valid),
        .ld_op_o      (ld_op),
        .ld_ofs_o     (ld_ofs)
    );

    // one ram per byte lane, lane k on bits 8k+7:8k
    for (genvar k = 0; k < mem_pkg::LANES; k++) begin : g_lane
        byte_lane_ram #(
            .MEM_AW (MEM_AW)
        ) u_ram (
            .clk     (clk),
            .addr_i  (lane_addr),
            .we_i    (lane_we[k]),
            .wdata_i (lane_wdata[k*mem_pkg::LANE_W +: mem_pkg::LANE_W]),
            .rdata_o (lane_rdata[k*mem_pkg::LANE_W +: mem_pkg::LANE_W])
        );
    end

    lsu_load_extract u_extract (
        .lane_rdata_i (lane_rdata),
        .ld_valid_i   (ld_valid),
        .ld_op_i      (ld_op),
        .ld_ofs_i     (ld_ofs),
        .rdata_o      (rdata_o),
        .rvalid_o     (rvalid_o)
    );

endmodule

/* hw/lsu_pkg.sv */
package lsu_pkg;

    // load/store opcodes, bit 3 marks a load
    typedef enum logic [3:0] {
        LS_NONE = 4'd0,
        SB      = 4'd1,
        SH      = 4'd2,
        SW      = 4'd4,
        SD      = 4'd5,
        LB      = 4'd9,
        LH      = 4'd10,
        LW      = 4'd11,
        LD      = 4'd12,
        LBU     = 4'd13,
        LHU     = 4'd14,
        LWU     = 4'd15
    } ls_op_e;

    // access size classes
    typedef enum logic [1:0] {
        SZ_B,
        SZ_H,
        SZ_W,
        SZ_D
    } ls_size_e;

    // size class of an opcode, LD/SD and LS_NONE fall to doubleword
    function automatic ls_size_e op_size(ls_op_e op);
        case (op)
            SB, LB, LBU: op_size = SZ_B;
            SH, LH, LHU: op_size = SZ_H;
            SW, LW, LWU: op_size = SZ_W;
            default:     op_size = SZ_D;
        endcase
    endfunction

endpackage

/* hw/lsu_store_align.sv */
`timescale 1ns/1ps

module lsu_store_align #(
    parameter int MEM_AW = 6
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         req_i,
    input  lsu_pkg::ls_op_e              op_i,
    input  logic [MEM_AW+mem_pkg::OFS_W-1:0] addr_i,
    input  logic [mem_pkg::XLEN-1:0]     wdata_i,
    output logic [MEM_AW-1:0]            lane_addr_o,
    output logic [mem_pkg::LANES-1:0]    lane_we_o,
    output logic [mem_pkg::XLEN-1:0]     lane_wdata_o,
    output logic                         ld_valid_o,
    output lsu_pkg::ls_op_e              ld_op_o,
    output logic [mem_pkg::OFS_W-1:0]    ld_ofs_o
);

    logic [mem_pkg::OFS_W-1:0] ofs;
    logic [mem_pkg::OFS_W-1:0] start;
    logic [mem_pkg::LANES-1:0] base_mask;
    lsu_pkg::ls_size_e         size;
    logic                      take;
    logic                      st_req;
    logic                      ld_req;

    assign ofs  = addr_i[mem_pkg::OFS_W-1:0];
    assign size = lsu_pkg::op_size(op_i);

    // bit 3 of the opcode splits loads from stores
    assign take   = req_i && (op_i != lsu_pkg::LS_NONE);
    assign st_req = take && !op_i[3];
    assign ld_req = take && op_i[3];

    // doubleword index shared by every lane
    assign lane_addr_o = addr_i[MEM_AW+mem_pkg::OFS_W-1:mem_pkg::OFS_W];

    // field start and width, low bits below the size are dropped
    always_comb begin
        case (size)
            lsu_pkg::SZ_B: begin
                start     = ofs;
                base_mask = 8'b0000_0001;
            end
            lsu_pkg::SZ_H: begin
                start     = {ofs[2:1], 1'b0};
                base_mask = 8'b0000_0011;
            end
            lsu_pkg::SZ_W: begin
                start     = {ofs[2], 2'b00};
                base_mask = 8'b0000_1111;
            end
            default: begin
                start     = '0;
                base_mask = 8'b1111_1111;
            end
        endcase
    end

    // strobe only on a store, loads never write
    assign lane_we_o = st_req ? (base_mask << start) : '0;

    // byte offset scaled to bits
    assign lane_wdata_o = wdata_i << {start, 3'b000};

    // load context lines up with the registered ram read
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ld_valid_o <= 1'b0;
        end else begin
            ld_valid_o <= ld_req;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_req) begin
            ld_op_o  <= op_i;
            ld_ofs_o <= ofs;
        end
    end

endmodule

/* hw/mem_pkg.sv */
package mem_pkg;

    // data path width
    parameter int XLEN = 64;

    // byte lanes across one doubleword
    parameter int LANES = 8;

    // width of one lane
    parameter int LANE_W = 8;

    // byte offset inside a doubleword
    parameter int OFS_W = 3;

endpackage

/* sources.f */
hw/lsu_pkg.sv
hw/mem_pkg.sv
hw/lsu_store_align.sv
hw/byte_lane_ram.sv
hw/lsu_load_extract.sv
hw/lsu_mem_top.sv
test/lsu_mem_sva.sv
test/tb_lsu_mem.sv

/* test/lsu_mem_sva.sv */
`timescale 1ns/1ps

module lsu_mem_sva (
    input logic       clk,
    input logic       rst_i,
    input logic       req_i,
    input logic [3:0] op_i,
    input logic [7:0] lane_we,
    input logic       rvalid_o
);

    logic st_req;
    logic ld_req;

    // bit 3 marks a load, code zero is no request
    assign st_req = req_i && (op_i != 4'd0) && !op_i[3];
    assign ld_req = req_i && op_i[3];

    // aligned byte, half, word or doubleword window
    function automatic logic legal_strobe(input logic [7:0] s);
        case (s)
            8'h01, 8'h02, 8'h04, 8'h08: return 1'b1;
            8'h10, 8'h20, 8'h40, 8'h80: return 1'b1;
            8'h03, 8'h0c, 8'h30, 8'hc0: return 1'b1;
            8'h0f, 8'hf0, 8'hff:        return 1'b1;
            default:                    return 1'b0;
        endcase
    endfunction

    no_we_without_store: assert property (@(posedge clk) !st_req |-> lane_we == 8'h00)
        else $error("lane write enable raised without a store request");

    strobe_shape: assert property (@(posedge clk) st_req |-> legal_strobe(lane_we))
        else $error("store strobe is not a legal byte window");

    load_response: assert property (@(posedge clk) ld_req && !rst_i |=> rvalid_o)
        else $error("load request got no response one cycle later");

    no_stray_response: assert property (@(posedge clk) rvalid_o |-> $past(ld_req && !rst_i))
        else $error("response valid without a load request");

    reset_quiet: assert property (@(posedge clk) rst_i |=> !rvalid_o)
        else $error("response valid while in reset");

endmodule

bind lsu_mem_top lsu_mem_sva u_sva (
    .clk      (clk),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .op_i     (op_i),
    .lane_we  (lane_we),
    .rvalid_o (rvalid_o)
);

/* test/tb_lsu_mem.sv */
`timescale 1ns/1ps

module tb_lsu_mem;

    localparam int MEM_AW    = 6;
    localparam int AW        = MEM_AW + 3;
    localparam int N_DW      = 2**MEM_AW;
    localparam int N_BYTES   = N_DW * 8;
    localparam int RST_CYC   = 16;
    localparam int N_RAND    = 120;
    localparam int N_IDLE    = 16;
    localparam int DW_STROBE = 9;
    localparam int DW_EXT    = 20;
    // fill and readback, strobe pairs, extension loads, random pairs, idle, reset, drain
    localparam int N_REQ = 3 * N_DW + 28 + 1 + 48 + 2 * N_RAND + N_IDLE + RST_CYC + 4;
    localparam int LIMIT = RST_CYC + N_REQ + 50;

    logic            clk;
    logic            rst_i;
    logic            req_i;
    lsu_pkg::ls_op_e op_i;
    logic [AW-1:0]   addr_i;
    logic [63:0]     wdata_i;
    logic [63:0]     rdata_o;
    logic            rvalid_o;

    logic [7:0]    mem_model [N_BYTES];
    logic [63:0]   exp_q [$];
    logic [AW-1:0] exp_addr_q [$];
    logic [63:0]   exp_val;
    logic [AW-1:0] exp_addr;
    logic [31:0]   lfsr_state;
    int            value_errs = 0;
    int            proto_errs = 0;
    int            cycle_cnt = 0;

    lsu_mem_top #(
        .MEM_AW (MEM_AW)
    ) dut (
        .clk      (clk),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .op_i     (op_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .rdata_o  (rdata_o),
        .rvalid_o (rvalid_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int op_bytes(input lsu_pkg::ls_op_e op);
        case (op)
            lsu_pkg::SB, lsu_pkg::LB, lsu_pkg::LBU: return 1;
            lsu_pkg::SH, lsu_pkg::LH, lsu_pkg::LHU: return 2;
            lsu_pkg::SW, lsu_pkg::LW, lsu_pkg::LWU: return 4;
            default:                                return 8;
        endcase
    endfunction

    function automatic logic is_load(input lsu_pkg::ls_op_e op);
        return op inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LD,
                          lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU};
    endfunction

    // first byte of the field with low offset bits below the size dropped
    function automatic int field_base(input lsu_pkg::ls_op_e op, input logic [AW-1:0] addr);
        int n;
        n = op_bytes(op);
        return int'(addr[AW-1:3]) * 8 + int'(addr[2:0]) / n * n;
    endfunction

    // expected load result from the byte array
    function automatic logic [63:0] ref_load(input lsu_pkg::ls_op_e op,
                                             input logic [AW-1:0] addr);
        int            n;
        int            sh;
        logic [AW-1:0] idx;
        logic [63:0]   v;
        n = op_bytes(op);
        sh = 64 - 8 * n;
        v = '0;
        for (int i = 0; i < n; i++) begin
            idx = AW'(field_base(op, addr) + i);
            v = v | (64'(mem_model[idx]) << (8 * i));
        end
        // field to the top and back down with or without sign
        v = v << sh;
        if (op inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW}) begin
            v = $signed(v) >>> sh;
        end else begin
            v = v >> sh;
        end
        return v;
    endfunction

    task automatic model_store(input lsu_pkg::ls_op_e op, input logic [AW-1:0] addr,
                               input logic [63:0] data);
        logic [AW-1:0] idx;
        for (int i = 0; i < op_bytes(op); i++) begin
            idx = AW'(field_base(op, addr) + i);
            mem_model[idx] = 8'(data >> (8 * i));
        end
    endtask

    function automatic lsu_pkg::ls_op_e pick_load(input logic [2:0] r);
        case (r)
            3'd0:    return lsu_pkg::LB;
            3'd1:    return lsu_pkg::LH;
            3'd2:    return lsu_pkg::LW;
            3'd3:    return lsu_pkg::LBU;
            3'd4:    return lsu_pkg::LHU;
            3'd5:    return lsu_pkg::LWU;
            default: return lsu_pkg::LD;
        endcase
    endfunction

    function automatic lsu_pkg::ls_op_e pick_store(input logic [1:0] r);
        case (r)
            2'd0:    return lsu_pkg::SB;
            2'd1:    return lsu_pkg::SH;
            2'd2:    return lsu_pkg::SW;
            default: return lsu_pkg::SD;
        endcase
    endfunction

    // one request per cycle
    // model updated at drive time
    task automatic issue(input lsu_pkg::ls_op_e op, input logic [AW-1:0] addr,
                         input logic [63:0] data);
        req_i = 1'b1;
        op_i = op;
        addr_i = addr;
        wdata_i = data;
        if (is_load(op)) begin
            exp_q.push_back(ref_load(op, addr));
            exp_addr_q.push_back(addr);
        end else if (op != lsu_pkg::LS_NONE) begin
            model_store(op, addr, data);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycle(input logic req, input lsu_pkg::ls_op_e op);
        req_i = req;
        op_i = op;
        addr_i = AW'(rand_bits(AW));
        wdata_i = rand_bits(64);
        @(posedge clk);
        #2;
    endtask

    always @(negedge clk) begin
        if (rvalid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("load response at %0t with no load outstanding", $time);
                proto_errs++;
            end else begin
                exp_val = exp_q.pop_front();
                exp_addr = exp_addr_q.pop_front();
                if (rdata_o !== exp_val) begin
                    $display("** Error at %0t: load at %h returned %h, expected %h",
                             $time, exp_addr, rdata_o, exp_val);
                    value_errs++;
                end
            end
        end else if (rvalid_o !== 1'b0) begin
            $display("response valid is unknown at %0t", $time);
            proto_errs++;
        end else if (rdata_o !== 64'h0) begin
            $display("** Error at %0t: read data %h while no response is valid",
                     $time, rdata_o);
            value_errs++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > LIMIT) begin
            $display("run did not finish within %0d cycles", LIMIT);
            $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        logic [AW-1:0]   a;
        lsu_pkg::ls_op_e op;
        lfsr_state = 32'h675e6d9d;
        rst_i = 1'b1;
        req_i = 1'b0;
        op_i = lsu_pkg::LS_NONE;
        addr_i = '0;
        wdata_i = '0;
        repeat (RST_CYC) @(posedge clk);
        #2;
        rst_i = 1'b0;

        // fill every doubleword, then read all back
        for (int i = 0; i < N_DW; i++) begin
            issue(lsu_pkg::SD, AW'(i * 8), rand_bits(64));
        end
        for (int i = 0; i < N_DW; i++) begin
            issue(lsu_pkg::LD, AW'(i * 8), '0);
        end

        // narrow stores each checked with a full doubleword load
        for (int o = 0; o < 8; o++) begin
            issue(lsu_pkg::SB, AW'(DW_STROBE * 8 + o), rand_bits(64));
            issue(lsu_pkg::LD, AW'(DW_STROBE * 8), '0);
        end
        for (int o = 0; o < 8; o += 2) begin
            issue(lsu_pkg::SH, AW'(DW_STROBE * 8 + o), rand_bits(64));
            issue(lsu_pkg::LD, AW'(DW_STROBE * 8), '0);
        end
        for (int o = 0; o < 8; o += 4) begin
            issue(lsu_pkg::SW, AW'(DW_STROBE * 8 + o), rand_bits(64));
            issue(lsu_pkg::LD, AW'(DW_STROBE * 8), '0);
        end

        // every byte, half and word has its top bit set
        issue(lsu_pkg::SD, AW'(DW_EXT * 8), 64'h80f1_82c3_84e5_86a7);
        for (int o = 0; o < 8; o++) begin
            issue(lsu_pkg::LB, AW'(DW_EXT * 8 + o), '0);
            issue(lsu_pkg::LH, AW'(DW_EXT * 8 + o), '0);
            issue(lsu_pkg::LW, AW'(DW_EXT * 8 + o), '0);
        end
        for (int o = 0; o < 8; o++) begin
            issue(lsu_pkg::LBU, AW'(DW_EXT * 8 + o), '0);
            issue(lsu_pkg::LHU, AW'(DW_EXT * 8 + o), '0);
            issue(lsu_pkg::LWU, AW'(DW_EXT * 8 + o), '0);
        end

        // back to back mix where each store is followed by a load of its doubleword
        for (int i = 0; i < N_RAND; i++) begin
            if (rand_bits(1) == 64'd1) begin
                op = pick_load(3'(rand_bits(3)));
            end else begin
                op = pick_store(2'(rand_bits(2)));
            end
            a = AW'(rand_bits(AW));
            issue(op, a, rand_bits(64));
            if (!is_load(op)) begin
                issue(pick_load(3'(rand_bits(3))), {a[AW-1:3], 3'(rand_bits(3))}, '0);
            end
        end

        // requests that must not be taken
        for (int i = 0; i < N_IDLE / 2; i++) begin
            idle_cycle(1'b1, lsu_pkg::LS_NONE);
        end
        for (int i = 0; i < N_IDLE / 2; i++) begin
            idle_cycle(1'b0, pick_store(2'(rand_bits(2))));
        end
        // loads during reset get no response
        rst_i = 1'b1;
        for (int i = 0; i < RST_CYC; i++) begin
            idle_cycle(1'b1, lsu_pkg::LD);
        end
        rst_i = 1'b0;
        for (int i = 0; i < N_DW; i++) begin
            issue(lsu_pkg::LD, AW'(i * 8), '0);
        end
        for (int i = 0; i < 4; i++) begin
            idle_cycle(1'b0, lsu_pkg::LS_NONE);
        end

        if (exp_q.size() != 0) begin
            $display("%0d load responses never arrived", exp_q.size());
            proto_errs++;
        end
        $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
